// File: castle_video.f
hdl/castle_pkg.sv
hdl/castle_timing.sv
hdl/castle_layer.sv
hdl/castle_prio.sv
hdl/castle_colmix.sv
hdl/castle_video.sv
testbench/castle_rom_model.sv
testbench/castle_video_tb.sv

// File: hdl/castle_colmix.sv
// Palette of 32 entries in 5:5:5, written by bytes; rgb and blanking trail the layers by PIPE_DELAY
module castle_colmix (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 pxl_cen,
    input  castle_pkg::scr_pos_t pos,
    input  castle_pkg::cpu_bus_t cpu,
    input  logic                 cs,
    input  logic [4:0]           col,
    output logic [7:0]           dout,
    output castle_pkg::rgb_t     rgb,
    output logic                 LHBL,
    output logic                 LVBL
);

    localparam int PD = castle_pkg::PIPE_DELAY;

    // Low byte holds red and part of green, high byte the rest
    logic [7:0]    pal_lo [0:castle_pkg::PAL_ENTRIES-1];
    logic [6:0]    pal_hi [0:castle_pkg::PAL_ENTRIES-1];
    logic [4:0]    cpu_idx;
    logic [14:0]   entry;
    logic [PD-1:0] hvis_dly;
    logic [PD-1:0] vvis_dly;
    logic          show;

    assign cpu_idx = cpu.addr[5:1];

    always_ff @(posedge clk) begin
        if (cs && cpu.we) begin
            if (cpu.addr[0]) begin
                pal_hi[cpu_idx] <= cpu.din[6:0];
            end else begin
                pal_lo[cpu_idx] <= cpu.din;
            end
        end
    end

    // Registered read port
    always_ff @(posedge clk) begin
        if (cs && !cpu.we) begin
            dout <= cpu.addr[0] ? {1'b0, pal_hi[cpu_idx]} : pal_lo[cpu_idx];
        end
    end

    assign entry = {pal_hi[col], pal_lo[col]};

    // Visibility follows the pixel through the same stages
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hvis_dly <= '0;
            vvis_dly <= '0;
        end else if (pxl_cen) begin
            hvis_dly <= {hvis_dly[PD-2:0], pos.hvis};
            vvis_dly <= {vvis_dly[PD-2:0], pos.vvis};
        end
    end

    assign LHBL = hvis_dly[PD-1];
    assign LVBL = vvis_dly[PD-1];
    assign show = hvis_dly[PD-2] && vvis_dly[PD-2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rgb <= '0;
        end else if (pxl_cen) begin
            if (show) begin
                rgb.red   <= entry[4:0];
                rgb.green <= entry[9:5];
                rgb.blue  <= entry[14:10];
            end else begin
                rgb <= '0;
            end
        end
    end

endmodule

// File: hdl/castle_layer.sv
// Tile layer with horizontal scroll in 4-pixel groups only; a late ROM word blanks its group
module castle_layer (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         pxl_cen,
    input  castle_pkg::scr_pos_t         pos,
    input  castle_pkg::cpu_bus_t         cpu,
    input  logic                         cs,
    output logic [7:0]                   dout,
    // Graphics ROM
    output logic                         rom_valid,
    output logic [castle_pkg::ROM_AW-1:0] rom_addr,
    input  logic                         rom_ready,
    input  logic [castle_pkg::ROM_DW-1:0] rom_data,
    input  logic                         rom_ok,
    output logic [3:0]                   pxl
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,
        ST_WAIT
    } req_state_e;

    req_state_e                    state;
    logic [5:0]                    scroll;
    logic [castle_pkg::ROM_DW-1:0] hold;
    logic                          hold_ok;
    logic                          stale;
    logic [castle_pkg::ROM_DW-5:0] shift;
    logic [castle_pkg::ROM_DW-1:0] word;
    logic                          boundary;
    logic                          rom_done;
    logic                          fresh;
    logic [3:0]                    grp_next;
    logic [5:0]                    col_next;
    logic [5:0]                    line_next;

    // Scroll register at address 0
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            scroll <= '0;
        end else if (cs && cpu.we && cpu.addr == 6'd0) begin
            scroll <= cpu.din[5:0];
        end
    end

    always_ff @(posedge clk) begin
        if (cs && !cpu.we) begin
            dout <= (cpu.addr == 6'd0) ? {2'b00, scroll} : 8'h00;
        end
    end

    // Next group to fetch, rolling into the following line after group 15
    assign grp_next = pos.hdump[5:2] + 4'd1;
    assign col_next = {2'b00, grp_next} + scroll;

    always_comb begin
        line_next = pos.vdump;
        if (grp_next == 4'd0) begin
            line_next = (pos.vdump == 6'(castle_pkg::V_TOTAL - 1)) ? 6'd0 : pos.vdump + 6'd1;
        end
    end

    assign boundary  = pxl_cen && pos.hdump[1:0] == 2'd0;
    assign rom_done  = state == ST_WAIT && rom_ok;
    assign fresh     = rom_done && !stale;
    assign rom_valid = state == ST_REQ;

    // A word arriving right on the boundary is still used
    assign word = hold_ok ? hold : (fresh ? rom_data : '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= ST_IDLE;
            hold_ok <= 1'b0;
            stale   <= 1'b0;
        end else begin
            case (state)
                ST_REQ: begin
                    if (rom_ready) begin
                        state <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (rom_ok) begin
                        state   <= ST_IDLE;
                        hold_ok <= !stale;
                        stale   <= 1'b0;
                    end
                end
                default: ;
            endcase
            // Boundary overrides, a request still in flight becomes stale
            if (boundary) begin
                hold_ok <= 1'b0;
                if (state == ST_IDLE || rom_done) begin
                    state <= ST_REQ;
                    stale <= 1'b0;
                end else begin
                    stale <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (boundary && (state == ST_IDLE || rom_done)) begin
            rom_addr <= {line_next, col_next};
        end
        if (rom_done) begin
            hold <= rom_data;
        end
        // Low nibble first
        if (pxl_cen) begin
            if (pos.hdump[1:0] == 2'd0) begin
                pxl   <= word[3:0];
                shift <= word[castle_pkg::ROM_DW-1:4];
            end else begin
                pxl   <= shift[3:0];
                shift <= shift >> 4;
            end
        end
    end

endmodule

// File: hdl/castle_pkg.sv
// Shared constants and types; the raster is a reduced 64x40 frame and scroll counts in 4-pixel groups
package castle_pkg;

    // Raster, counted in pixels and lines
    localparam int H_TOTAL   = 64;
    localparam int H_VISIBLE = 48;
    localparam int HS_START  = 52;
    localparam int HS_LEN    = 4;
    localparam int V_TOTAL   = 40;
    localparam int V_VISIBLE = 32;
    localparam int VS_START  = 34;
    localparam int VS_LEN    = 2;

    // Clocks per pixel, and pixels from layer output to rgb
    localparam int PXL_DIV    = 4;
    localparam int PIPE_DELAY = 3;

    // Memory widths and depths
    localparam int ROM_AW      = 12;
    localparam int ROM_DW      = 16;
    localparam int PAL_ENTRIES = 32;
    localparam int PRIO_AW     = 6;

    // Single-cycle CPU strobe, shared by all chip selects
    typedef struct packed {
        logic       we;
        logic [5:0] addr;
        logic [7:0] din;
    } cpu_bus_t;

    // Raster position with undelayed visibility
    typedef struct packed {
        logic [5:0] hdump;
        logic [5:0] vdump;
        logic       hvis;
        logic       vvis;
    } scr_pos_t;

    typedef struct packed {
        logic [4:0] red;
        logic [4:0] green;
        logic [4:0] blue;
    } rgb_t;

    // Priority PROM output code
    typedef enum logic [1:0] {
        SEL_LAYER1   = 2'd0,
        SEL_LAYER2   = 2'd1,
        SEL_BACKDROP = 2'd2
    } prio_sel_e;

endpackage

// File: hdl/castle_prio.sv
// Priority PROM of 64x2, read once per pixel; codes other than the two layers give backdrop
module castle_prio (
    input  logic                          clk,
    input  logic                          pxl_cen,
    input  logic                          prog_we,
    input  logic [castle_pkg::PRIO_AW-1:0] prog_addr,
    input  logic [1:0]                    prog_data,
    input  logic                          prio,
    input  logic [3:0]                    l1_pxl,
    input  logic [3:0]                    l2_pxl,
    output logic [4:0]                    col
);

    logic [1:0]                    prom [0:(1 << castle_pkg::PRIO_AW)-1];
    logic [castle_pkg::PRIO_AW-1:0] rd_addr;
    castle_pkg::prio_sel_e         sel;
    logic                          l1_opaque;
    logic                          l2_opaque;

    always_ff @(posedge clk) begin
        if (prog_we) begin
            prom[prog_addr] <= prog_data;
        end
    end

    assign l1_opaque = |l1_pxl;
    assign l2_opaque = |l2_pxl;
    assign rd_addr   = {prio, l2_opaque, l1_pxl};
    assign sel       = castle_pkg::prio_sel_e'(prom[rd_addr]);

    // Transparent pick falls back to entry 0
    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            case (sel)
                castle_pkg::SEL_LAYER1: begin
                    col <= {1'b0, l1_pxl};
                end
                castle_pkg::SEL_LAYER2: begin
                    col <= l2_opaque ? {1'b1, l2_pxl} : 5'd0;
                end
                default: begin
                    col <= 5'd0;
                end
            endcase
        end
    end

endmodule

// File: hdl/castle_timing.sv
// Raster timing from a single clock; pxl_cen is one clock in PXL_DIV and all counters run on it
module castle_timing (
    input  logic                 clk,
    input  logic                 rst_n,
    output logic                 pxl_cen,
    output logic                 pxl2_cen,
    output logic                 HS,
    output logic                 VS,
    output castle_pkg::scr_pos_t pos
);

    localparam int DIV_W = $clog2(castle_pkg::PXL_DIV);

    logic [DIV_W-1:0] cen_cnt;
    logic [5:0]       hcnt;
    logic [5:0]       vcnt;

    // Clock enable divider
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cen_cnt <= '0;
        end else begin
            cen_cnt <= cen_cnt + 1'b1;
        end
    end

    // pxl_cen lands on every second pxl2_cen
    assign pxl2_cen = cen_cnt[0];
    assign pxl_cen  = cen_cnt == DIV_W'(castle_pkg::PXL_DIV - 1);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hcnt <= '0;
            vcnt <= '0;
        end else if (pxl_cen) begin
            if (hcnt == 6'(castle_pkg::H_TOTAL - 1)) begin
                hcnt <= '0;
                // Frame wraps with the last line
                if (vcnt == 6'(castle_pkg::V_TOTAL - 1)) begin
                    vcnt <= '0;
                end else begin
                    vcnt <= vcnt + 6'd1;
                end
            end else begin
                hcnt <= hcnt + 6'd1;
            end
        end
    end

    // Sync pulses, one clock behind the counters
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            HS <= 1'b0;
            VS <= 1'b0;
        end else begin
            HS <= hcnt >= 6'(castle_pkg::HS_START) &&
                  hcnt <  6'(castle_pkg::HS_START + castle_pkg::HS_LEN);
            VS <= vcnt >= 6'(castle_pkg::VS_START) &&
                  vcnt <  6'(castle_pkg::VS_START + castle_pkg::VS_LEN);
        end
    end

    always_comb begin
        pos.hdump = hcnt;
        pos.vdump = vcnt;
        pos.hvis  = hcnt < 6'(castle_pkg::H_VISIBLE);
        pos.vvis  = vcnt < 6'(castle_pkg::V_VISIBLE);
    end

endmodule

// File: hdl/castle_video.sv
// Dual-layer video top; no sprites, no vertical scroll, one clock domain with pixel enables
module castle_video (
    input  logic                          clk,
    input  logic                          rst_n,
    // CPU
    input  castle_pkg::cpu_bus_t          cpu,
    input  logic                          gfx1_cs,
    input  logic                          gfx2_cs,
    input  logic                          pal_cs,
    output logic [7:0]                    gfx1_dout,
    output logic [7:0]                    gfx2_dout,
    output logic [7:0]                    pal_dout,
    // Priority PROM
    input  logic                          prio,
    input  logic                          prog_we,
    input  logic [castle_pkg::PRIO_AW-1:0] prog_addr,
    input  logic [1:0]                    prog_data,
    // Graphics ROMs
    output logic                          gfx1_rom_valid,
    output logic [castle_pkg::ROM_AW-1:0]  gfx1_rom_addr,
    input  logic                          gfx1_rom_ready,
    input  logic [castle_pkg::ROM_DW-1:0]  gfx1_rom_data,
    input  logic                          gfx1_rom_ok,
    output logic                          gfx2_rom_valid,
    output logic [castle_pkg::ROM_AW-1:0]  gfx2_rom_addr,
    input  logic                          gfx2_rom_ready,
    input  logic [castle_pkg::ROM_DW-1:0]  gfx2_rom_data,
    input  logic                          gfx2_rom_ok,
    // Video out
    output logic                          pxl_cen,
    output logic                          pxl2_cen,
    output logic                          HS,
    output logic                          VS,
    output logic                          LHBL,
    output logic                          LVBL,
    output castle_pkg::rgb_t              rgb
);

    castle_pkg::scr_pos_t pos;
    logic [3:0]           gfx1_pxl;
    logic [3:0]           gfx2_pxl;
    logic [4:0]           col;

    castle_timing u_timing (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .pxl_cen  ( pxl_cen  ),
        .pxl2_cen ( pxl2_cen ),
        .HS       ( HS       ),
        .VS       ( VS       ),
        .pos      ( pos      )
    );

    castle_layer u_gfx1 (
        .clk       ( clk            ),
        .rst_n     ( rst_n          ),
        .pxl_cen   ( pxl_cen        ),
        .pos       ( pos            ),
        .cpu       ( cpu            ),
        .cs        ( gfx1_cs        ),
        .dout      ( gfx1_dout      ),
        .rom_valid ( gfx1_rom_valid ),
        .rom_addr  ( gfx1_rom_addr  ),
        .rom_ready ( gfx1_rom_ready ),
        .rom_data  ( gfx1_rom_data  ),
        .rom_ok    ( gfx1_rom_ok    ),
        .pxl       ( gfx1_pxl       )
    );

    castle_layer u_gfx2 (
        .clk       ( clk            ),
        .rst_n     ( rst_n          ),
        .pxl_cen   ( pxl_cen        ),
        .pos       ( pos            ),
        .cpu       ( cpu            ),
        .cs        ( gfx2_cs        ),
        .dout      ( gfx2_dout      ),
        .rom_valid ( gfx2_rom_valid ),
        .rom_addr  ( gfx2_rom_addr  ),
        .rom_ready ( gfx2_rom_ready ),
        .rom_data  ( gfx2_rom_data  ),
        .rom_ok    ( gfx2_rom_ok    ),
        .pxl       ( gfx2_pxl       )
    );

    castle_prio u_prio (
        .clk       ( clk       ),
        .pxl_cen   ( pxl_cen   ),
        .prog_we   ( prog_we   ),
        .prog_addr ( prog_addr ),
        .prog_data ( prog_data ),
        .prio      ( prio      ),
        .l1_pxl    ( gfx1_pxl  ),
        .l2_pxl    ( gfx2_pxl  ),
        .col       ( col       )
    );

    castle_colmix u_colmix (
        .clk     ( clk      ),
        .rst_n   ( rst_n    ),
        .pxl_cen ( pxl_cen  ),
        .pos     ( pos      ),
        .cpu     ( cpu      ),
        .cs      ( pal_cs   ),
        .col     ( col      ),
        .dout    ( pal_dout ),
        .rgb     ( rgb      ),
        .LHBL    ( LHBL     ),
        .LVBL    ( LVBL     )
    );

endmodule

// File: run_sim.sh
#!/bin/sh
verilator --binary --timing --top-module castle_video_tb -f castle_video.f -o castle_sim || exit 1
out=$(./obj_dir/castle_sim)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q "^Testbench passed$" && exit 0 || exit 1

// File: testbench/castle_rom_model.sv
// Graphics ROM responder; ready is random but never low for more than 3 clocks, answers in 1 to 6
module castle_rom_model (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        valid,
    input  logic [11:0] addr,
    output logic        ready,
    output logic [15:0] data,
    output logic        ok
);

    integer      seed = 53893;
    logic        busy;
    logic [2:0]  delay;
    logic [1:0]  wait_cnt;
    logic [11:0] addr_lat;
    logic [31:0] r;
    logic [31:0] prod;

    initial begin
        ready = 1'b0;
        data  = 16'h0000;
        ok    = 1'b0;
    end

    // Decisions made here take effect at the following rising edge
    always @(negedge clk) begin
        ok = 1'b0;
        if (!rst_n) begin
            ready    = 1'b0;
            busy     = 1'b0;
            delay    = 3'd0;
            wait_cnt = 2'd0;
        end else begin
            if (busy) begin
                if (delay == 3'd0) begin
                    prod = {20'd0, addr_lat} * 32'h0000_9E37;
                    data = prod[15:0] ^ 16'h5A5A;
                    ok   = 1'b1;
                    busy = 1'b0;
                end else begin
                    delay = delay - 3'd1;
                end
            end
            r        = $random(seed);
            ready    = r[0] || wait_cnt == 2'd3;
            wait_cnt = (valid && !ready) ? wait_cnt + 2'd1 : 2'd0;
            // Valid and this ready meet at the next rising edge
            if (valid && ready && !busy) begin
                busy     = 1'b1;
                addr_lat = addr;
                r        = $unsigned($random(seed));
                delay    = 3'(r % 6);
            end
        end
    end

endmodule

// File: testbench/castle_video_tb.sv
// Self-checking testbench; pixel checks cover two full frames, one for each prio setting
module castle_video_tb;

    localparam int FRAME_CLKS = 64 * 40 * 4;
    localparam int TIMEOUT    = (4 * FRAME_CLKS + 2000) * 10;

    logic                 clk = 1'b0;
    logic                 rst_n;
    castle_pkg::cpu_bus_t cpu;
    logic                 gfx1_cs, gfx2_cs, pal_cs;
    logic [7:0]           gfx1_dout, gfx2_dout, pal_dout;
    logic                 prio, prog_we;
    logic [5:0]           prog_addr;
    logic [1:0]           prog_data;
    logic                 gfx1_rom_valid, gfx1_rom_ready, gfx1_rom_ok;
    logic                 gfx2_rom_valid, gfx2_rom_ready, gfx2_rom_ok;
    logic [11:0]          gfx1_rom_addr, gfx2_rom_addr;
    logic [15:0]          gfx1_rom_data, gfx2_rom_data;
    logic                 pxl_cen, pxl2_cen, HS, VS, LHBL, LVBL;
    castle_pkg::rgb_t     rgb;
    castle_pkg::rgb_t     exp;

    integer      seed = 53893;
    int          errors = 0;
    int          checks = 0;
    int          cyc = 0;
    int          hpos = 0;
    int          vpos = 0;
    int          hs_last = -1;
    int          vs_last = -1;
    int          cen_last = -1;
    int          frame_pix = 0;
    logic        cen_seen = 1'b0;
    logic        check_on = 1'b0;
    logic        lhbl_q = 1'b0;
    logic        lvbl_q = 1'b0;
    logic        hs_q = 1'b0;
    logic        vs_q = 1'b0;
    logic [14:0] pal [0:31];
    logic [5:0]  scroll1, scroll2;

    castle_video DUT (.*);

    castle_rom_model u_rom1 (
        .clk(clk), .rst_n(rst_n), .valid(gfx1_rom_valid), .addr(gfx1_rom_addr),
        .ready(gfx1_rom_ready), .data(gfx1_rom_data), .ok(gfx1_rom_ok)
    );

    castle_rom_model u_rom2 (
        .clk(clk), .rst_n(rst_n), .valid(gfx2_rom_valid), .addr(gfx2_rom_addr),
        .ready(gfx2_rom_ready), .data(gfx2_rom_data), .ok(gfx2_rom_ok)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cyc      <= cyc + 1;
        cen_seen <= pxl_cen;
    end

    task automatic report_value(input string name, input logic [31:0] expv,
                                input logic [31:0] actv);
        errors++;
        $display("FAIL %s expected %0h actual %0h", name, expv, actv);
    endtask

    function automatic logic [15:0] gfx_word(input logic [11:0] addr);
        logic [31:0] full;
        full = {20'd0, addr} * 32'h0000_9E37;
        return full[15:0] ^ 16'h5A5A;
    endfunction

    // Nibble k of the group word is the pixel at offset k
    function automatic logic [3:0] layer_pixel(input logic [5:0] x, input logic [5:0] y,
                                               input logic [5:0] scroll);
        logic [5:0]  grp;
        logic [15:0] w;
        grp = {2'b00, x[5:2]} + scroll;
        w   = gfx_word({y, grp});
        return w[{x[1:0], 2'b00} +: 4];
    endfunction

    function automatic castle_pkg::rgb_t expected_rgb(input logic [5:0] x, input logic [5:0] y);
        logic [3:0]       p1, p2;
        logic [4:0]       c;
        logic [14:0]      e;
        castle_pkg::rgb_t r;
        p1 = layer_pixel(x, y, scroll1);
        p2 = layer_pixel(x, y, scroll2);
        c  = 5'd0;
        if (!prio) begin
            if (p1 != 4'd0) c = {1'b0, p1};
            else if (p2 != 4'd0) c = {1'b1, p2};
        end else begin
            if (p2 != 4'd0) c = {1'b1, p2};
            else if (p1 != 4'd0) c = {1'b0, p1};
        end
        e       = pal[c];
        r.red   = e[4:0];
        r.green = e[9:5];
        r.blue  = e[14:10];
        return r;
    endfunction

    // Raster monitor, sampled half a clock after each pixel edge
    always @(negedge clk) begin
        if (rst_n) begin
            // pxl_cen every 4 clocks, pxl2_cen on every second clock in step with it
            if (pxl_cen) begin
                if (cen_last >= 0) begin
                    checks++;
                    assert (cyc - cen_last == 4)
                        else report_value("pxl_cen_period", 4, cyc - cen_last);
                end
                cen_last = cyc;
            end
            if (cen_last >= 0) begin
                checks++;
                assert (pxl2_cen == ((cyc - cen_last) % 2 == 0))
                    else report_value("pxl2_cen", 32'((cyc - cen_last) % 2 == 0), 32'(pxl2_cen));
            end
            if (HS && !hs_q) begin
                if (hs_last >= 0) begin
                    checks++;
                    assert (cyc - hs_last == 256) else report_value("hs_period", 256, cyc - hs_last);
                end
                hs_last = cyc;
            end
            if (VS && !vs_q) begin
                if (vs_last >= 0) begin
                    checks++;
                    assert (cyc - vs_last == FRAME_CLKS)
                        else report_value("vs_period", FRAME_CLKS, cyc - vs_last);
                end
                vs_last = cyc;
            end
            if (cen_seen) begin
                if (!LHBL || !LVBL) begin
                    checks++;
                    assert (rgb == '0) else report_value("blank_rgb", 0, 32'(rgb));
                end
                if (LHBL && LVBL && check_on) begin
                    exp = expected_rgb(6'(hpos), 6'(vpos));
                    checks++;
                    frame_pix++;
                    assert (rgb == exp) else report_value("pixel", 32'(exp), 32'(rgb));
                end
                if (LHBL) begin
                    hpos++;
                end else begin
                    if (lhbl_q) begin
                        checks++;
                        assert (hpos == 48) else report_value("line_pixels", 48, hpos);
                        if (LVBL) vpos++;
                    end
                    hpos = 0;
                end
                if (!LVBL) begin
                    if (lvbl_q) begin
                        checks++;
                        assert (vpos == 32) else report_value("frame_lines", 32, vpos);
                    end
                    vpos = 0;
                end
                lhbl_q = LHBL;
                lvbl_q = LVBL;
            end
            hs_q = HS;
            vs_q = VS;
        end
    end

    task automatic check_idle(input string name);
        checks++;
        assert (!gfx1_rom_valid && !gfx2_rom_valid && !HS && !VS && !LHBL && !LVBL && rgb == '0)
        else begin
            errors++;
            $display("%s: outputs not idle during or right after reset", name);
        end
    endtask

    // Chip select mask is {pal, gfx2, gfx1}
    task automatic cpu_write(input logic [2:0] sel, input logic [5:0] addr, input logic [7:0] data);
        @(negedge clk);
        cpu.we   = 1'b1;
        cpu.addr = addr;
        cpu.din  = data;
        {pal_cs, gfx2_cs, gfx1_cs} = sel;
        @(negedge clk);
        cpu.we = 1'b0;
        {pal_cs, gfx2_cs, gfx1_cs} = 3'b000;
    endtask

    task automatic cpu_read(input logic [2:0] sel, input logic [5:0] addr,
                            input logic [7:0] expv, input string name);
        logic [7:0] got;
        @(negedge clk);
        cpu.we   = 1'b0;
        cpu.addr = addr;
        {pal_cs, gfx2_cs, gfx1_cs} = sel;
        @(negedge clk);
        {pal_cs, gfx2_cs, gfx1_cs} = 3'b000;
        got = sel[2] ? pal_dout : (sel[1] ? gfx2_dout : gfx1_dout);
        checks++;
        assert (got == expv) else report_value(name, 32'(expv), 32'(got));
    endtask

    task automatic set_scroll(input logic [5:0] s1, input logic [5:0] s2);
        scroll1 = s1;
        scroll2 = s2;
        cpu_write(3'b001, 6'd0, {2'b00, s1});
        cpu_write(3'b010, 6'd0, {2'b00, s2});
        cpu_read(3'b001, 6'd0, {2'b00, s1}, "gfx1_scroll");
        cpu_read(3'b010, 6'd0, {2'b00, s2}, "gfx2_scroll");
    endtask

    // Checks the first whole frame that starts after the next VS
    task automatic check_frame(input string name);
        @(posedge VS);
        @(posedge LVBL);
        frame_pix = 0;
        check_on  = 1'b1;
        @(negedge LVBL);
        check_on = 1'b0;
        checks++;
        assert (frame_pix == 48 * 32) else report_value(name, 48 * 32, frame_pix);
    endtask

    initial begin
        rst_n     = 1'b0;
        cpu       = '0;
        gfx1_cs   = 1'b0;
        gfx2_cs   = 1'b0;
        pal_cs    = 1'b0;
        prio      = 1'b0;
        prog_we   = 1'b0;
        prog_addr = 6'd0;
        prog_data = 2'd0;
        scroll1   = 6'd0;
        scroll2   = 6'd0;
        repeat (8) begin
            @(negedge clk);
            check_idle("reset");
        end
        rst_n = 1'b1;
        @(negedge clk);
        check_idle("after_reset");

        // PROM address is {prio, layer 2 opaque, layer 1 pixel}
        for (int a = 0; a < 64; a++) begin
            @(negedge clk);
            prog_we   = 1'b1;
            prog_addr = 6'(a);
            if (a < 32) prog_data = (a % 16 != 0) ? 2'd0 : 2'd1;
            else prog_data = (a % 32 >= 16) ? 2'd1 : 2'd0;
        end
        @(negedge clk);
        prog_we = 1'b0;

        for (int i = 0; i < 32; i++) begin
            pal[i] = 15'($random(seed));
            cpu_write(3'b100, 6'(2 * i), pal[i][7:0]);
            cpu_write(3'b100, 6'(2 * i + 1), {1'b0, pal[i][14:8]});
        end
        for (int i = 0; i < 32; i++) begin
            cpu_read(3'b100, 6'(2 * i), pal[i][7:0], "pal_low");
            cpu_read(3'b100, 6'(2 * i + 1), {1'b0, pal[i][14:8]}, "pal_high");
        end

        set_scroll(6'd0, 6'd3);
        check_frame("frame_prio0");

        @(negedge clk);
        prio = 1'b1;
        set_scroll(6'd17, 6'd42);
        check_frame("frame_prio1");

        repeat (10) @(negedge clk);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT);
        $display("Timeout: the run did not reach its end in time");
        $display("Testbench failed");
        $finish;
    end

endmodule
